/* Bender.yml */
package:
  name: lsu_subsys

sources:
  # packages first, then the bus, then the design from the leaves up
  - source/lsu_pkg.sv
  - source/axi_lite_pkg.sv
  - source/axi_lite_if.sv
  - source/lfsr4.sv
  - source/lsu.sv
  - source/axi_lite_sram.sv
  - source/lsu_subsys.sv

  - target: simulation
    files:
      - sim/lsu_subsys_chk.sv
      - sim/tb_lsu_subsys.sv

/* list.f */
source/lsu_pkg.sv
source/axi_lite_pkg.sv
source/axi_lite_if.sv
source/lfsr4.sv
source/lsu.sv
source/axi_lite_sram.sv
source/lsu_subsys.sv
sim/lsu_subsys_chk.sv
sim/tb_lsu_subsys.sv

/* sim/lsu_subsys_chk.sv */
// assertions bound into the LSU: bus valid stability, the result pulse
// and quiet bus while idle
module lsu_subsys_chk (
	input logic                clk,
	input logic                rstn,
	input lsu_pkg::lsu_state_e state_i,
	input logic [31:0]         ar_addr_i,
	input logic                ar_valid_i,
	input logic                ar_ready_i,
	input logic [31:0]         aw_addr_i,
	input logic                aw_valid_i,
	input logic                aw_ready_i,
	input logic [31:0]         w_data_i,
	input logic [3:0]          w_strb_i,
	input logic                w_valid_i,
	input logic                w_ready_i,
	input logic                done_i,
	input logic                busy_i
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	ar_hold: assert property (@(posedge clk) disable iff (rstn)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
		else begin
			$error("read address valid dropped or address changed before ready");
			fail_count++;
		end

	aw_hold: assert property (@(posedge clk) disable iff (rstn)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
		else begin
			$error("write address valid dropped or address changed before ready");
			fail_count++;
		end

	w_hold: assert property (@(posedge clk) disable iff (rstn)
		w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i))
		else begin
			$error("write data valid dropped or payload changed before ready");
			fail_count++;
		end

	// single-cycle result, then back to idle
	done_pulse: assert property (@(posedge clk) disable iff (rstn)
		done_i |=> !done_i)
		else begin
			$error("done_o held longer than one cycle");
			fail_count++;
		end

	done_idle: assert property (@(posedge clk) disable iff (rstn)
		done_i |=> !busy_i)
		else begin
			$error("busy_o still high after done_o");
			fail_count++;
		end

	idle_quiet: assert property (@(posedge clk) disable iff (rstn)
		state_i == lsu_pkg::S_IDLE |-> !(ar_valid_i || aw_valid_i || w_valid_i))
		else begin
			$error("bus valid raised while LSU is idle");
			fail_count++;
		end

endmodule

bind lsu lsu_subsys_chk i_lsu_chk (
	.clk       (clk),
	.rstn      (rstn),
	.state_i   (state_q),
	.ar_addr_i (bus.ar_addr),
	.ar_valid_i(bus.ar_valid),
	.ar_ready_i(bus.ar_ready),
	.aw_addr_i (bus.aw_addr),
	.aw_valid_i(bus.aw_valid),
	.aw_ready_i(bus.aw_ready),
	.w_data_i  (bus.w_data),
	.w_strb_i  (bus.w_strb),
	.w_valid_i (bus.w_valid),
	.w_ready_i (bus.w_ready),
	.done_i    (done_o),
	.busy_i    (busy_o)
);

/* sim/tb_lsu_subsys.sv */
// testbench for the LSU subsystem: directed and random loads, stores and
// pass-through operations, checked against a shadow memory model
module tb_lsu_subsys;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_AW     = 8;
	localparam int N_RANDOM   = 300;
	localparam int N_OPS      = 66 + N_RANDOM;
	localparam int TIMEOUT_NS = (N_OPS * 60 + 20) * 10;

	logic                 clk;
	logic                 rstn;
	logic                 op_valid_i;
	lsu_pkg::load_type_e  load_type_i;
	lsu_pkg::store_type_e store_type_i;
	logic [31:0]          addr_i;
	logic [31:0]          wdata_i;
	logic [4:0]           reg_i;
	logic                 we_i;
	logic                 busy_o;
	logic                 done_o;
	logic [31:0]          rd_data_o;
	logic [4:0]           rd_reg_o;
	logic                 rd_we_o;
	logic                 err_o;

	integer      seed;
	int          errors = 0;
	int          checked = 0;
	int          cycle = 0;
	logic [31:0] shadow [2**MEM_AW];

	// one entry per issued operation, oldest first
	string       name_q [$];
	logic [31:0] data_q [$];
	logic        err_q [$];
	logic [4:0]  reg_q [$];
	logic        we_q [$];
	int          cyc_q [$];

	lsu_subsys #(
		.MEM_AW(MEM_AW)
	) i_lsu_subsys (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic int unsigned rand_below(int unsigned n);
		logic [31:0] v;
		v = $random(seed);
		return v % n;
	endfunction

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// expected {err, data} of one operation; stores update the shadow memory
	function automatic logic [32:0] model(lsu_pkg::load_type_e ld, lsu_pkg::store_type_e st,
		logic [31:0] addr, logic [31:0] wdata);
		logic [31:0]       w;
		logic [7:0]        b;
		logic [15:0]       h;
		logic              in_range;
		logic [MEM_AW-1:0] idx;
		in_range = addr[31:MEM_AW+2] == '0;
		idx = addr[MEM_AW+1:2];
		w = shadow[idx];
		b = w[8*addr[1:0] +: 8];
		h = w[16*addr[1] +: 16];
		if (ld != lsu_pkg::LD_NONE) begin
			if (!in_range)
				return {1'b1, 32'h0};
			case (ld)
				lsu_pkg::LD_LB:  return {1'b0, {24{b[7]}}, b};
				lsu_pkg::LD_LH:  return {1'b0, {16{h[15]}}, h};
				lsu_pkg::LD_LBU: return {1'b0, 24'h0, b};
				lsu_pkg::LD_LHU: return {1'b0, 16'h0, h};
				default:         return {1'b0, w};
			endcase
		end
		// non-memory operation hands back the ALU result
		if (st == lsu_pkg::ST_NONE)
			return {1'b0, addr};
		if (!in_range)
			return {1'b1, 32'h0};
		case (st)
			lsu_pkg::ST_SB: shadow[idx][8*addr[1:0] +: 8] = wdata[7:0];
			lsu_pkg::ST_SH: shadow[idx][16*addr[1] +: 16] = wdata[15:0];
			default:        shadow[idx] = wdata;
		endcase
		return {1'b0, addr};
	endfunction

	task automatic check_quiet(input string when_s);
		if (busy_o !== 1'b0 || done_o !== 1'b0 || err_o !== 1'b0) begin
			errors++;
			$display("busy_o, done_o and err_o are not all low %s", when_s);
		end
	endtask

	task automatic check_value(input string test, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s %s expected %h actual %h", test, what, exp, act);
		end
	endtask

	task automatic run_op(input string name, input lsu_pkg::load_type_e ld,
		input lsu_pkg::store_type_e st, input logic [31:0] addr, input logic [31:0] wdata,
		input bit junk);
		logic [32:0] exp;
		@(negedge clk);
		while (busy_o)
			@(negedge clk);
		exp = model(ld, st, addr, wdata);
		op_valid_i   = 1'b1;
		load_type_i  = ld;
		store_type_i = st;
		addr_i       = addr;
		wdata_i      = wdata;
		reg_i        = 5'(rand_below(32));
		we_i         = rand_below(2) == 1;
		name_q.push_back(name);
		data_q.push_back(exp[31:0]);
		err_q.push_back(exp[32]);
		reg_q.push_back(reg_i);
		we_q.push_back(we_i);
		// pass-through result is seen two edges after the strobe
		if (ld == lsu_pkg::LD_NONE && st == lsu_pkg::ST_NONE)
			cyc_q.push_back(cycle + 2);
		else
			cyc_q.push_back(-1);
		@(negedge clk);
		op_valid_i = 1'b0;
		if (junk && busy_o) begin
			// LSU is busy, this store must be dropped
			op_valid_i   = 1'b1;
			load_type_i  = lsu_pkg::LD_NONE;
			store_type_i = lsu_pkg::ST_SW;
			addr_i       = 32'h0;
			wdata_i      = 32'hdead_beef;
			@(negedge clk);
			op_valid_i = 1'b0;
		end
	endtask

	always @(negedge clk) begin
		if (!rstn && done_o) begin
			if (name_q.size() == 0) begin
				errors++;
				$display("result pulse at %0t ns with no operation outstanding", $time);
			end else begin
				check_value(name_q[0], "rd_data_o", data_q[0], rd_data_o);
				check_value(name_q[0], "err_o", err_q[0], err_o);
				check_value(name_q[0], "rd_reg_o", reg_q[0], rd_reg_o);
				check_value(name_q[0], "rd_we_o", we_q[0], rd_we_o);
				if (cyc_q[0] >= 0)
					check_value(name_q[0], "done cycle", cyc_q[0], cycle);
				void'(name_q.pop_front());
				void'(data_q.pop_front());
				void'(err_q.pop_front());
				void'(reg_q.pop_front());
				void'(we_q.pop_front());
				void'(cyc_q.pop_front());
				checked++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired, operations did not finish within %0d ns", TIMEOUT_NS);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] a;
		int unsigned k;
		bit          j;
		int          chk_fails;
		seed         = 32'h5732_b44a;
		op_valid_i   = 1'b0;
		load_type_i  = lsu_pkg::LD_NONE;
		store_type_i = lsu_pkg::ST_NONE;
		addr_i       = '0;
		wdata_i      = '0;
		reg_i        = '0;
		we_i         = 1'b0;
		for (int i = 0; i < 2**MEM_AW; i++)
			shadow[i] = '0;
		rstn = 1'b1;
		repeat (5) begin
			@(negedge clk);
			check_quiet("during reset");
		end
		rstn = 1'b0;
		@(negedge clk);
		check_quiet("after reset");

		// memory reads back as zero before any store
		for (int i = 0; i < 8; i++)
			run_op("reset_read", lsu_pkg::LD_LW, lsu_pkg::ST_NONE, 32'(i * 36), 32'h0, 0);

		for (int i = 0; i < 4; i++)
			run_op("store_lanes", lsu_pkg::LD_NONE, lsu_pkg::ST_SB, 32'h40 + i, rand32(), 0);
		for (int i = 0; i < 2; i++) begin
			run_op("store_lanes", lsu_pkg::LD_NONE, lsu_pkg::ST_SH, 32'h44 + 2 * i, rand32(), 0);
			run_op("store_lanes", lsu_pkg::LD_NONE, lsu_pkg::ST_SH, 32'h4d + 2 * i, rand32(), 0);
		end
		run_op("store_lanes", lsu_pkg::LD_NONE, lsu_pkg::ST_SW, 32'h48, rand32(), 0);
		for (int i = 0; i < 4; i++)
			run_op("store_lanes", lsu_pkg::LD_LW, lsu_pkg::ST_NONE, 32'h40 + 4 * i, 32'h0, 0);

		// sign bits set in every byte and halfword
		run_op("load_ext", lsu_pkg::LD_NONE, lsu_pkg::ST_SW, 32'h50, 32'h80ff_7f81, 0);
		run_op("load_ext", lsu_pkg::LD_NONE, lsu_pkg::ST_SW, 32'h54, 32'hff80_017f, 0);
		for (int w = 0; w < 2; w++) begin
			for (int i = 0; i < 4; i++) begin
				a = 32'h50 + 4 * w + i;
				run_op("load_ext", lsu_pkg::LD_LB, lsu_pkg::ST_NONE, a, 32'h0, 0);
				run_op("load_ext", lsu_pkg::LD_LBU, lsu_pkg::ST_NONE, a, 32'h0, 0);
				run_op("load_ext", lsu_pkg::LD_LH, lsu_pkg::ST_NONE, a, 32'h0, 0);
				run_op("load_ext", lsu_pkg::LD_LHU, lsu_pkg::ST_NONE, a, 32'h0, 0);
			end
		end

		for (int i = 0; i < 4; i++)
			run_op("pass_through", lsu_pkg::LD_NONE, lsu_pkg::ST_NONE, rand32(), rand32(), 0);

		// out-of-range aliases of word 0x58 must leave it untouched
		run_op("range", lsu_pkg::LD_NONE, lsu_pkg::ST_SW, 32'h58, 32'h1234_5678, 0);
		run_op("range", lsu_pkg::LD_NONE, lsu_pkg::ST_SW, 32'h458, rand32(), 0);
		run_op("range", lsu_pkg::LD_NONE, lsu_pkg::ST_SB, 32'h8000_0058, rand32(), 0);
		run_op("range", lsu_pkg::LD_NONE, lsu_pkg::ST_SH, 32'h0010_005a, rand32(), 0);
		run_op("range", lsu_pkg::LD_LW, lsu_pkg::ST_NONE, 32'h458, 32'h0, 0);
		run_op("range", lsu_pkg::LD_LBU, lsu_pkg::ST_NONE, 32'hffff_fc58, 32'h0, 0);
		run_op("range", lsu_pkg::LD_LW, lsu_pkg::ST_NONE, 32'h58, 32'h0, 0);

		for (int n = 0; n < N_RANDOM; n++) begin
			k = rand_below(3);
			j = rand_below(4) == 0;
			a = {22'h0, 8'(rand_below(64)), 2'(rand_below(4))};
			if (rand_below(16) == 0)
				a[10 + rand_below(22)] = 1'b1;
			if (k == 0)
				run_op("random_mix", lsu_pkg::load_type_e'(3'(1 + rand_below(5))),
					lsu_pkg::ST_NONE, a, 32'h0, j);
			else if (k == 1)
				run_op("random_mix", lsu_pkg::LD_NONE,
					lsu_pkg::store_type_e'(2'(1 + rand_below(3))), a, rand32(), j);
			else
				run_op("random_mix", lsu_pkg::LD_NONE, lsu_pkg::ST_NONE, rand32(), rand32(), j);
		end

		while (name_q.size() != 0 || busy_o)
			@(negedge clk);
		chk_fails = i_lsu_subsys.i_lsu.i_lsu_chk.fail_count;
		$display("errors: %0d, assertion failures: %0d, results checked: %0d",
			errors, chk_fails, checked);
		if (errors == 0 && chk_fails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* source/axi_lite_if.sv */
// five-channel AXI-lite bus, master side for the LSU and slave side
// for the memory
interface axi_lite_if;

	// read address
	logic [axi_lite_pkg::ADDR_W-1:0] ar_addr;
	logic                            ar_valid;
	logic                            ar_ready;

	// read data
	logic [axi_lite_pkg::DATA_W-1:0] r_data;
	axi_lite_pkg::resp_e             r_resp;
	logic                            r_valid;
	logic                            r_ready;

	// write address
	logic [axi_lite_pkg::ADDR_W-1:0] aw_addr;
	logic                            aw_valid;
	logic                            aw_ready;

	// write data
	logic [axi_lite_pkg::DATA_W-1:0] w_data;
	logic [axi_lite_pkg::STRB_W-1:0] w_strb;
	logic                            w_valid;
	logic                            w_ready;

	// write response
	axi_lite_pkg::resp_e             b_resp;
	logic                            b_valid;
	logic                            b_ready;

	modport master (
		output ar_addr, ar_valid, input ar_ready,
		input r_data, r_resp, r_valid, output r_ready,
		output aw_addr, aw_valid, input aw_ready,
		output w_data, w_strb, w_valid, input w_ready,
		input b_resp, b_valid, output b_ready
	);

	modport slave (
		input ar_addr, ar_valid, output ar_ready,
		output r_data, r_resp, r_valid, input r_ready,
		input aw_addr, aw_valid, output aw_ready,
		input w_data, w_strb, w_valid, output w_ready,
		output b_resp, b_valid, input b_ready
	);

endinterface

/* source/axi_lite_pkg.sv */
// widths and response codes of the AXI-lite bus between the LSU
// and the data memory
package axi_lite_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// one strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;

	// only the two codes this subsystem produces
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

endpackage

/* source/axi_lite_sram.sv */
// word-addressed SRAM behind an AXI-lite slave port, with random ready
// delays; addresses beyond the array answer with SLVERR
module axi_lite_sram #(
	parameter int         MEM_AW = 8,
	parameter logic [3:0] SEED   = 4'b0110
) (
	input  logic      clk,
	input  logic      rstn,
	axi_lite_if.slave bus
);

	localparam int DEPTH = 2 ** MEM_AW;

	logic [axi_lite_pkg::DATA_W-1:0] mem [DEPTH];
	logic [3:0]                      rnd;
	logic [3:0]                      rnd_ch [3];
	logic [3:0]                      cnt_q [3];
	logic [2:0]                      arm_q;
	logic [2:0]                      want;
	logic [2:0]                      rdy;
	logic                            r_valid_q;
	logic                            b_valid_q;
	logic                            aw_taken_q;
	logic                            w_taken_q;
	logic [axi_lite_pkg::ADDR_W-1:0] awaddr_q;
	logic [axi_lite_pkg::DATA_W-1:0] wdata_q;
	logic [axi_lite_pkg::STRB_W-1:0] wstrb_q;
	logic [axi_lite_pkg::ADDR_W-1:0] wr_addr;
	logic [axi_lite_pkg::DATA_W-1:0] wr_data;
	logic [axi_lite_pkg::STRB_W-1:0] wr_strb;
	logic                            ar_fire;
	logic                            aw_fire;
	logic                            w_fire;
	logic                            wr_go;
	logic                            rd_ok;
	logic                            wr_ok;

	lfsr4 i_lfsr (.clk, .rstn, .seed_i(SEED), .advance_i(|(want & ~arm_q)), .value_o(rnd));

	assign rnd_ch[0] = rnd;
	assign rnd_ch[1] = {rnd[2:0], rnd[3]};
	assign rnd_ch[2] = {rnd[1:0], rnd[3:2]};

	// channel 0 read address, 1 write address, 2 write data
	assign want[0] = bus.ar_valid && !r_valid_q;
	assign want[1] = bus.aw_valid && !aw_taken_q && !b_valid_q;
	assign want[2] = bus.w_valid && !w_taken_q && !b_valid_q;

	always_ff @(posedge clk) begin
		if (rstn) begin
			arm_q <= '0;
			for (int i = 0; i < 3; i++)
				cnt_q[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!arm_q[i]) begin
					if (want[i]) begin
						arm_q[i] <= 1'b1;
						cnt_q[i] <= rnd_ch[i];
					end
				end else if (want[i] && rdy[i]) begin
					arm_q[i] <= 1'b0;
				end else if (cnt_q[i] != 4'd0) begin
					cnt_q[i] <= cnt_q[i] - 4'd1;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 3; i++)
			rdy[i] = arm_q[i] && (cnt_q[i] == 4'd0) && want[i];
	end

	assign bus.ar_ready = rdy[0];
	assign bus.aw_ready = rdy[1];
	assign bus.w_ready  = rdy[2];
	assign ar_fire = bus.ar_valid && rdy[0];
	assign aw_fire = bus.aw_valid && rdy[1];
	assign w_fire  = bus.w_valid && rdy[2];

	// write goes ahead on the edge where its second half arrives
	assign wr_go   = (aw_taken_q || aw_fire) && (w_taken_q || w_fire);
	assign wr_addr = aw_taken_q ? awaddr_q : bus.aw_addr;
	assign wr_data = w_taken_q ? wdata_q : bus.w_data;
	assign wr_strb = w_taken_q ? wstrb_q : bus.w_strb;
	assign wr_ok   = wr_addr[axi_lite_pkg::ADDR_W-1:MEM_AW+2] == '0;
	assign rd_ok   = bus.ar_addr[axi_lite_pkg::ADDR_W-1:MEM_AW+2] == '0;

	always_ff @(posedge clk) begin
		if (rstn) begin
			r_valid_q  <= 1'b0;
			b_valid_q  <= 1'b0;
			aw_taken_q <= 1'b0;
			w_taken_q  <= 1'b0;
		end else begin
			if (ar_fire)
				r_valid_q <= 1'b1;
			else if (bus.r_ready)
				r_valid_q <= 1'b0;
			if (wr_go)
				b_valid_q <= 1'b1;
			else if (bus.b_ready)
				b_valid_q <= 1'b0;
			aw_taken_q <= !wr_go && (aw_taken_q || aw_fire);
			w_taken_q  <= !wr_go && (w_taken_q || w_fire);
		end
	end

	// response payload and half-done write
	always_ff @(posedge clk) begin
		if (aw_fire)
			awaddr_q <= bus.aw_addr;
		if (w_fire) begin
			wdata_q <= bus.w_data;
			wstrb_q <= bus.w_strb;
		end
		if (ar_fire) begin
			bus.r_data <= rd_ok ? mem[bus.ar_addr[MEM_AW+1:2]] : '0;
			bus.r_resp <= rd_ok ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
		end
		if (wr_go)
			bus.b_resp <= wr_ok ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else if (wr_go && wr_ok) begin
			for (int b = 0; b < axi_lite_pkg::STRB_W; b++) begin
				if (wr_strb[b])
					mem[wr_addr[MEM_AW+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	assign bus.r_valid = r_valid_q;
	assign bus.b_valid = b_valid_q;

endmodule

/* source/lfsr4.sv */
// 4-bit maximal-length LFSR, x^4+x^3+1, stepped on request
// the owner draws a fresh handshake delay from value_o when it advances
module lfsr4 (
	input  logic       clk,
	input  logic       rstn,
	input  logic [3:0] seed_i,
	input  logic       advance_i,
	output logic [3:0] value_o
);

	logic [3:0] state_q;

	always_ff @(posedge clk) begin
		if (rstn) begin
			// seed must be nonzero or the register locks up
			state_q <= seed_i;
		end else if (advance_i) begin
			state_q <= {state_q[2:0], state_q[3] ^ state_q[2]};
		end
	end

	assign value_o = state_q;

endmodule

/* source/lsu.sv */
// load/store unit: accepts one operation strobe, runs it as an AXI-lite
// master transfer with random handshake delays, returns one result pulse
module lsu #(
	parameter logic [3:0] SEED = 4'b0001
) (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            op_valid_i,
	input  lsu_pkg::load_type_e             load_type_i,
	input  lsu_pkg::store_type_e            store_type_i,
	input  logic [axi_lite_pkg::ADDR_W-1:0] addr_i,
	input  logic [lsu_pkg::XLEN-1:0]        wdata_i,
	input  logic [4:0]                      reg_i,
	input  logic                            we_i,
	output logic                            busy_o,
	output logic                            done_o,
	output logic [lsu_pkg::XLEN-1:0]        rd_data_o,
	output logic [4:0]                      rd_reg_o,
	output logic                            rd_we_o,
	output logic                            err_o,
	axi_lite_if.master                      bus
);

	lsu_pkg::lsu_state_e             state_q;
	lsu_pkg::load_type_e             load_q;
	lsu_pkg::store_type_e            store_q;
	logic [axi_lite_pkg::ADDR_W-1:0] addr_q;
	logic [lsu_pkg::XLEN-1:0]        wdata_q;
	logic [4:0]                      reg_q;
	logic                            we_q;
	logic [lsu_pkg::XLEN-1:0]        rd_data_q;
	logic                            err_q;
	logic                            aw_done_q;
	logic                            w_done_q;
	logic [3:0]                      addr_dly_q;
	logic [3:0]                      w_dly_q;
	logic [3:0]                      rsp_dly_q;
	logic [3:0]                      addr_rnd;
	logic [3:0]                      w_rnd;
	logic [3:0]                      rsp_rnd;
	logic                            accept;
	logic                            is_load;
	logic                            is_store;
	logic                            ar_fire;
	logic                            aw_fire;
	logic                            w_fire;
	logic                            r_fire;
	logic                            b_fire;
	logic                            req_done;
	logic                            rsp_draw;
	logic                            rsp_err;
	lsu_pkg::mem_word_u              st_word;
	logic [axi_lite_pkg::STRB_W-1:0] st_strb;
	lsu_pkg::mem_word_u              ld_word;
	logic [7:0]                      ld_byte;
	logic [15:0]                     ld_half;
	logic [lsu_pkg::XLEN-1:0]        ld_ext;

	// rotated seeds keep the three delay streams apart
	lfsr4 i_lfsr_addr (.clk, .rstn, .seed_i(SEED), .advance_i(accept), .value_o(addr_rnd));
	lfsr4 i_lfsr_wdata (
		.clk, .rstn, .seed_i({SEED[2:0], SEED[3]}), .advance_i(accept), .value_o(w_rnd)
	);
	lfsr4 i_lfsr_rsp (
		.clk, .rstn, .seed_i({SEED[1:0], SEED[3:2]}), .advance_i(rsp_draw), .value_o(rsp_rnd)
	);

	assign accept   = (state_q == lsu_pkg::S_IDLE) && op_valid_i;
	assign is_load  = load_q != lsu_pkg::LD_NONE;
	assign is_store = !is_load && (store_q != lsu_pkg::ST_NONE);
	assign ar_fire  = bus.ar_valid && bus.ar_ready;
	assign aw_fire  = bus.aw_valid && bus.aw_ready;
	assign w_fire   = bus.w_valid && bus.w_ready;
	assign r_fire   = bus.r_valid && bus.r_ready;
	assign b_fire   = bus.b_valid && bus.b_ready;

	// a store's address and data may land in different cycles
	assign req_done = is_load ? ar_fire :
		(aw_done_q || aw_fire) && (w_done_q || w_fire);
	assign rsp_draw = (state_q == lsu_pkg::S_ADDR) && (is_load || is_store) && req_done;
	assign rsp_err  = is_load ? (bus.r_resp == axi_lite_pkg::RESP_SLVERR) :
		(bus.b_resp == axi_lite_pkg::RESP_SLVERR);

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q    <= lsu_pkg::S_IDLE;
			aw_done_q  <= 1'b0;
			w_done_q   <= 1'b0;
			addr_dly_q <= '0;
			w_dly_q    <= '0;
			rsp_dly_q  <= '0;
			err_q      <= 1'b0;
		end else begin
			case (state_q)
				lsu_pkg::S_IDLE: begin
					if (accept) begin
						state_q    <= lsu_pkg::S_ADDR;
						aw_done_q  <= 1'b0;
						w_done_q   <= 1'b0;
						addr_dly_q <= addr_rnd;
						w_dly_q    <= w_rnd;
					end
				end
				lsu_pkg::S_ADDR: begin
					if (!is_load && !is_store) begin
						state_q <= lsu_pkg::S_DONE;
						err_q   <= 1'b0;
					end else if (req_done) begin
						state_q   <= lsu_pkg::S_RESP;
						rsp_dly_q <= rsp_rnd;
					end else begin
						if (addr_dly_q != 4'd0)
							addr_dly_q <= addr_dly_q - 4'd1;
						if (w_dly_q != 4'd0)
							w_dly_q <= w_dly_q - 4'd1;
						if (aw_fire)
							aw_done_q <= 1'b1;
						if (w_fire)
							w_done_q <= 1'b1;
					end
				end
				lsu_pkg::S_RESP: begin
					if (r_fire || b_fire) begin
						state_q <= lsu_pkg::S_DONE;
						err_q   <= rsp_err;
					end else if (rsp_dly_q != 4'd0) begin
						rsp_dly_q <= rsp_dly_q - 4'd1;
					end
				end
				default: state_q <= lsu_pkg::S_IDLE;
			endcase
		end
	end

	// operation payload and result word
	always_ff @(posedge clk) begin
		if (accept) begin
			load_q  <= load_type_i;
			store_q <= store_type_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
			reg_q   <= reg_i;
			we_q    <= we_i;
		end
		if ((state_q == lsu_pkg::S_ADDR) && !is_load && !is_store)
			rd_data_q <= addr_q;
		else if (r_fire)
			rd_data_q <= rsp_err ? '0 : ld_ext;
		else if (b_fire)
			rd_data_q <= rsp_err ? '0 : addr_q;
	end

	// store lane placement
	always_comb begin
		st_word = '0;
		st_strb = '0;
		case (store_q)
			lsu_pkg::ST_SB: begin
				st_word.bytes[addr_q[1:0]] = wdata_q[7:0];
				st_strb[addr_q[1:0]]       = 1'b1;
			end
			lsu_pkg::ST_SH: begin
				st_word.halves[addr_q[1]] = wdata_q[15:0];
				st_strb = addr_q[1] ? 4'b1100 : 4'b0011;
			end
			lsu_pkg::ST_SW: begin
				st_word.bytes = wdata_q;
				st_strb       = 4'b1111;
			end
			default: st_strb = '0;
		endcase
	end

	// load lane selection and extension
	assign ld_word = bus.r_data;
	assign ld_byte = ld_word.bytes[addr_q[1:0]];
	assign ld_half = ld_word.halves[addr_q[1]];

	always_comb begin
		case (load_q)
			lsu_pkg::LD_LB:  ld_ext = {{(lsu_pkg::XLEN-8){ld_byte[7]}}, ld_byte};
			lsu_pkg::LD_LH:  ld_ext = {{(lsu_pkg::XLEN-16){ld_half[15]}}, ld_half};
			lsu_pkg::LD_LBU: ld_ext = {{(lsu_pkg::XLEN-8){1'b0}}, ld_byte};
			lsu_pkg::LD_LHU: ld_ext = {{(lsu_pkg::XLEN-16){1'b0}}, ld_half};
			default:         ld_ext = ld_word.bytes;
		endcase
	end

	// valids wait for their delay to run out
	assign bus.ar_addr  = addr_q;
	assign bus.ar_valid = (state_q == lsu_pkg::S_ADDR) && is_load && (addr_dly_q == 4'd0);
	assign bus.aw_addr  = addr_q;
	assign bus.aw_valid = (state_q == lsu_pkg::S_ADDR) && is_store && !aw_done_q &&
		(addr_dly_q == 4'd0);
	assign bus.w_data   = st_word;
	assign bus.w_strb   = st_strb;
	assign bus.w_valid  = (state_q == lsu_pkg::S_ADDR) && is_store && !w_done_q &&
		(w_dly_q == 4'd0);
	assign bus.r_ready  = (state_q == lsu_pkg::S_RESP) && is_load && (rsp_dly_q == 4'd0);
	assign bus.b_ready  = (state_q == lsu_pkg::S_RESP) && is_store && (rsp_dly_q == 4'd0);

	assign busy_o    = state_q != lsu_pkg::S_IDLE;
	assign done_o    = state_q == lsu_pkg::S_DONE;
	assign rd_data_o = rd_data_q;
	assign rd_reg_o  = reg_q;
	assign rd_we_o   = we_q;
	assign err_o     = err_q;

endmodule

/* source/lsu_pkg.sv */
// shared types of the load/store unit: operation encodings, FSM states
// and the memory word view used for lane selection
package lsu_pkg;

	localparam int XLEN = 32;

	// load kinds as decoded from the instruction
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_type_e;

	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_SB   = 2'd1,
		ST_SH   = 2'd2,
		ST_SW   = 2'd3
	} store_type_e;

	// idle, bus request phase, bus response phase, result pulse
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_ADDR = 2'd1,
		S_RESP = 2'd2,
		S_DONE = 2'd3
	} lsu_state_e;

	// one memory word, addressed by byte lane or by halfword
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} mem_word_u;

endpackage

/* source/lsu_subsys.sv */
// LSU together with its data memory; plain operation strobe in,
// busy level and one result pulse out
module lsu_subsys #(
	parameter int         MEM_AW   = 8,
	parameter logic [3:0] LSU_SEED = 4'b1001,
	parameter logic [3:0] MEM_SEED = 4'b0110
) (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            op_valid_i,
	input  lsu_pkg::load_type_e             load_type_i,
	input  lsu_pkg::store_type_e            store_type_i,
	input  logic [axi_lite_pkg::ADDR_W-1:0] addr_i,
	input  logic [lsu_pkg::XLEN-1:0]        wdata_i,
	input  logic [4:0]                      reg_i,
	input  logic                            we_i,
	output logic                            busy_o,
	output logic                            done_o,
	output logic [lsu_pkg::XLEN-1:0]        rd_data_o,
	output logic [4:0]                      rd_reg_o,
	output logic                            rd_we_o,
	output logic                            err_o
);

	axi_lite_if bus ();

	lsu #(
		.SEED(LSU_SEED)
	) i_lsu (
		.clk,
		.rstn,
		.op_valid_i,
		.load_type_i,
		.store_type_i,
		.addr_i,
		.wdata_i,
		.reg_i,
		.we_i,
		.busy_o,
		.done_o,
		.rd_data_o,
		.rd_reg_o,
		.rd_we_o,
		.err_o,
		.bus (bus.master)
	);

	// data memory, 2^MEM_AW words
	axi_lite_sram #(
		.MEM_AW(MEM_AW),
		.SEED  (MEM_SEED)
	) i_sram (
		.clk,
		.rstn,
		.bus (bus.slave)
	);

endmodule
